/* dbg_pkg.sv */
////////////////////////////////////////////////////////////
// Debug server package: field types, protocol byte codes,
// memory size and the control FSM states
////////////////////////////////////////////////////////////

`default_nettype none

package dbg_pkg;

  // Field widths
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  mem_addr_t;
  typedef logic [15:0] len_t;
  typedef logic [63:0] entry_t;
  typedef logic [31:0] word_t;

  localparam int unsigned MemBytes = 256;

  // Host command codes
  localparam byte_t CmdRead  = 8'h11;
  localparam byte_t CmdWrite = 8'h12;
  localparam byte_t CmdExec  = 8'h13;

  // Target responses, ACK doubles as the challenge byte
  localparam byte_t RespAck = 8'h06;
  localparam byte_t RespEot = 8'h04;
  localparam byte_t RespEoc = 8'h14;

  typedef enum logic [3:0] {
    StIdle,
    StHeader,
    StAck,
    StWrData,
    StRdReq,
    StRdSend,
    StEot,
    StEoc,
    StExit
  } ctrl_state_e;

endpackage

`default_nettype wire

/* dbg_field_if.sv */
////////////////////////////////////////////////////////////
// Control to field datapath strobes and field status
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface dbg_field_if import dbg_pkg::*; ();

  // Strobes from control
  logic      shift_addr;
  logic      shift_len;
  byte_t     field_byte;
  logic      step;
  logic      load_exit;
  logic      shift_exit;
  logic      load_entry;

  // Field state back to control and memory
  logic      len_done;
  byte_t     exit_byte;
  entry_t    entry;
  mem_addr_t cur_addr;

  modport ctrl (
    output shift_addr, shift_len, field_byte, step, load_exit, shift_exit, load_entry,
    input  len_done, exit_byte
  );

  modport fields (
    input  shift_addr, shift_len, field_byte, step, load_exit, shift_exit, load_entry,
    output len_done, exit_byte, entry, cur_addr
  );

  modport mem (
    input cur_addr
  );

endinterface

`default_nettype wire

/* dbg_mem_if.sv */
////////////////////////////////////////////////////////////
// Control to memory write and read port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface dbg_mem_if import dbg_pkg::*; ();

  logic  we;
  byte_t wdata;
  logic  rd_en;
  // Valid one cycle after rd_en
  byte_t rdata;

  modport ctrl (
    output we, wdata, rd_en,
    input  rdata
  );

  modport mem (
    input  we, wdata, rd_en,
    output rdata
  );

endinterface

`default_nettype wire

/* uart_rx.sv */
////////////////////////////////////////////////////////////
// UART 8N1 receiver, mid-bit sampling, LSB first
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module uart_rx import dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_data_o
);

  localparam int unsigned CntW = $clog2(2 * ClksPerBit);
  localparam logic [CntW-1:0] HalfCnt = CntW'(ClksPerBit / 2 - 1);
  localparam logic [CntW-1:0] BitCnt  = CntW'(ClksPerBit - 1);
  // Back in idle exactly when a back-to-back start bit reaches the synchronizer
  localparam logic [CntW-1:0] EndCnt  = CntW'(ClksPerBit + ClksPerBit / 2 - 2);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_e;

  rx_state_e       state_q;
  logic            rx_meta_q;
  logic            rx_sync_q;
  logic [CntW-1:0] cnt_q;
  logic [2:0]      bit_q;
  logic            valid_q;
  logic            sample;
  byte_t           data_q;

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign sample = (state_q == RxData) && (cnt_q == BitCnt);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= RxIdle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt_q   <= cnt_q + 1'b1;
      unique case (state_q)
        RxIdle: begin
          cnt_q <= '0;
          bit_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RxStart;
          end
        end
        RxStart: begin
          // Glitch shorter than half a bit returns to idle
          if (cnt_q == HalfCnt) begin
            cnt_q   <= '0;
            state_q <= rx_sync_q ? RxIdle : RxData;
          end
        end
        RxData: begin
          if (sample) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RxStop;
            end
          end
        end
        RxStop: begin
          // Framing error drops the byte
          if (cnt_q == BitCnt && !rx_sync_q) begin
            state_q <= RxIdle;
          end else if (cnt_q == EndCnt) begin
            valid_q <= 1'b1;
            state_q <= RxIdle;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      data_q <= {rx_sync_q, data_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_data_o  = data_q;

endmodule

`default_nettype wire

/* uart_tx.sv */
////////////////////////////////////////////////////////////
// UART 8N1 transmitter with busy level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module uart_tx import dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  tx_start_i,
  input  byte_t tx_data_i,
  output logic  tx_o,
  output logic  tx_busy_o
);

  localparam int unsigned CntW = $clog2(ClksPerBit);

  logic            busy_q;
  logic            tx_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      bit_q;
  logic            bit_end;
  // Data bits followed by the stop bit
  logic [8:0]      shift_q;

  assign bit_end = busy_q && (cnt_q == CntW'(ClksPerBit - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      tx_q   <= 1'b1;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q <= 1'b1;
        tx_q   <= 1'b0;
        cnt_q  <= '0;
        bit_q  <= '0;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (bit_end) begin
        cnt_q <= '0;
        bit_q <= bit_q + 1'b1;
        // Bit 9 is the stop bit, line stays high afterwards
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end else begin
          tx_q <= shift_q[0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_start_i && !busy_q) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx_o      = tx_q;
  assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

/* dbg_cmd_fields.sv */
////////////////////////////////////////////////////////////
// Address, length, entry and exit-code registers
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dbg_cmd_fields import dbg_pkg::*; (
  input  logic         clk,
  input  logic         rst_i,
  input  word_t        exit_code_i,
  dbg_field_if.fields  field_if
);

  entry_t addr_q;
  len_t   len_q;
  word_t  exit_q;
  entry_t entry_q;

  // Little-endian fields, each new byte enters at the top
  always_ff @(posedge clk) begin
    if (field_if.shift_addr) begin
      addr_q <= {field_if.field_byte, addr_q[63:8]};
    end else if (field_if.step) begin
      addr_q <= addr_q + 64'd1;
    end
    if (field_if.shift_len) begin
      len_q <= {field_if.field_byte, len_q[15:8]};
    end else if (field_if.step) begin
      len_q <= len_q - 16'd1;
    end
    if (field_if.load_exit) begin
      exit_q <= exit_code_i;
    end else if (field_if.shift_exit) begin
      exit_q <= {8'h00, exit_q[31:8]};
    end
  end

  // Entry holds until the next exec, loaded with the last address byte
  always_ff @(posedge clk) begin
    if (rst_i) begin
      entry_q <= '0;
    end else if (field_if.load_entry) begin
      entry_q <= {field_if.field_byte, addr_q[63:8]};
    end
  end

  assign field_if.cur_addr  = addr_q[7:0];
  assign field_if.len_done  = (len_q == '0);
  assign field_if.exit_byte = exit_q[7:0];
  assign field_if.entry     = entry_q;

endmodule

`default_nettype wire

/* dbg_mem.sv */
////////////////////////////////////////////////////////////
// Byte memory with synchronous write and registered read
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dbg_mem import dbg_pkg::*; (
  input  logic      clk,
  dbg_mem_if.mem    mem_if,
  dbg_field_if.mem  field_if
);

  byte_t mem_q [MemBytes];
  byte_t rdata_q;

  // Index is 8 bits wide, so addresses wrap
  always_ff @(posedge clk) begin
    if (mem_if.we) begin
      mem_q[field_if.cur_addr] <= mem_if.wdata;
    end
    if (mem_if.rd_en) begin
      rdata_q <= mem_q[field_if.cur_addr];
    end
  end

  assign mem_if.rdata = rdata_q;

endmodule

`default_nettype wire

/* dbg_ctrl.sv */
////////////////////////////////////////////////////////////
// Debug protocol FSM: command decode, header count,
// data transfer and reply byte selection
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dbg_ctrl import dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       rx_valid_i,
  input  byte_t      rx_data_i,
  input  logic       tx_busy_i,
  input  logic       eoc_i,
  output logic       tx_start_o,
  output byte_t      tx_data_o,
  output logic       exec_o,
  dbg_field_if.ctrl  field_if,
  dbg_mem_if.ctrl    mem_if
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  byte_t       cmd_q;
  logic [3:0]  cnt_q;
  logic        hdr_last;
  logic        exec_q;

  // Exec sends only the entry address, read and write add a length
  assign hdr_last = (cmd_q == CmdExec) ? (cnt_q == 4'd7) : (cnt_q == 4'd15);

  assign field_if.field_byte = rx_data_i;
  assign mem_if.wdata        = rx_data_i;

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d             = state_q;
    tx_start_o          = 1'b0;
    tx_data_o           = RespAck;
    field_if.shift_addr = 1'b0;
    field_if.shift_len  = 1'b0;
    field_if.step       = 1'b0;
    field_if.load_exit  = 1'b0;
    field_if.shift_exit = 1'b0;
    field_if.load_entry = 1'b0;
    mem_if.we           = 1'b0;
    mem_if.rd_en        = 1'b0;
    unique case (state_q)
      StIdle: begin
        if (eoc_i) begin
          field_if.load_exit = 1'b1;
          state_d            = StEoc;
        end else if (rx_valid_i) begin
          if (rx_data_i == RespAck) begin
            state_d = StAck;
          end else if (rx_data_i inside {CmdRead, CmdWrite, CmdExec}) begin
            state_d = StHeader;
          end
        end
      end
      StHeader: begin
        if (rx_valid_i) begin
          // Only the two low length bytes are kept
          field_if.shift_addr = (cnt_q < 4'd8);
          field_if.shift_len  = (cnt_q == 4'd8) || (cnt_q == 4'd9);
          field_if.load_entry = hdr_last && (cmd_q == CmdExec);
          if (hdr_last) begin
            state_d = StAck;
          end
        end
      end
      StAck: begin
        tx_start_o = !tx_busy_i;
        if (!tx_busy_i) begin
          case (cmd_q)
            CmdWrite: state_d = StWrData;
            CmdRead:  state_d = StRdReq;
            default:  state_d = StIdle;
          endcase
        end
      end
      StWrData: begin
        if (field_if.len_done) begin
          state_d = StEot;
        end else if (rx_valid_i) begin
          mem_if.we     = 1'b1;
          field_if.step = 1'b1;
        end
      end
      StRdReq: begin
        if (field_if.len_done) begin
          state_d = StEot;
        end else begin
          mem_if.rd_en = 1'b1;
          state_d      = StRdSend;
        end
      end
      StRdSend: begin
        tx_data_o  = mem_if.rdata;
        tx_start_o = !tx_busy_i;
        if (!tx_busy_i) begin
          field_if.step = 1'b1;
          state_d       = StRdReq;
        end
      end
      StEot: begin
        tx_data_o  = RespEot;
        tx_start_o = !tx_busy_i;
        if (!tx_busy_i) begin
          state_d = StIdle;
        end
      end
      StEoc: begin
        tx_data_o  = RespEoc;
        tx_start_o = !tx_busy_i;
        if (!tx_busy_i) begin
          state_d = StExit;
        end
      end
      StExit: begin
        // Exit code goes out LSB first
        tx_data_o  = field_if.exit_byte;
        tx_start_o = !tx_busy_i;
        if (!tx_busy_i) begin
          field_if.shift_exit = 1'b1;
          if (cnt_q == 4'd3) begin
            state_d = StIdle;
          end
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= StIdle;
      cmd_q   <= '0;
      cnt_q   <= '0;
      exec_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      exec_q  <= field_if.load_entry;
      if (state_q == StIdle && rx_valid_i) begin
        cmd_q <= rx_data_i;
      end
      // One counter for header bytes and exit-code bytes
      if (state_d != state_q) begin
        cnt_q <= '0;
      end else if ((state_q == StHeader && rx_valid_i) || (state_q == StExit && tx_start_o)) begin
        cnt_q <= cnt_q + 4'd1;
      end
    end
  end

  assign exec_o = exec_q;

endmodule

`default_nettype wire

/* dbg_uart_server.sv */
////////////////////////////////////////////////////////////
// UART debug server top: receiver, transmitter, control,
// field registers and memory
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dbg_uart_server import dbg_pkg::*; #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic   clk,
  input  logic   rst_i,
  input  logic   uart_rx_i,
  input  logic   eoc_i,
  input  word_t  exit_code_i,
  output logic   uart_tx_o,
  output logic   exec_o,
  output entry_t entry_o
);

  logic  rx_valid;
  byte_t rx_data;
  logic  tx_start;
  byte_t tx_data;
  logic  tx_busy;

  dbg_field_if field_if ();
  dbg_mem_if   mem_if ();

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_rx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_data_o  ( rx_data   )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .tx_start_i ( tx_start  ),
    .tx_data_i  ( tx_data   ),
    .tx_o       ( uart_tx_o ),
    .tx_busy_o  ( tx_busy   )
  );

  dbg_ctrl i_dbg_ctrl (
    .clk        ( clk      ),
    .rst_i      ( rst_i    ),
    .rx_valid_i ( rx_valid ),
    .rx_data_i  ( rx_data  ),
    .tx_busy_i  ( tx_busy  ),
    .eoc_i      ( eoc_i    ),
    .tx_start_o ( tx_start ),
    .tx_data_o  ( tx_data  ),
    .exec_o     ( exec_o   ),
    .field_if   ( field_if ),
    .mem_if     ( mem_if   )
  );

  dbg_cmd_fields i_dbg_cmd_fields (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .exit_code_i ( exit_code_i ),
    .field_if    ( field_if    )
  );

  dbg_mem i_dbg_mem (
    .clk      ( clk      ),
    .mem_if   ( mem_if   ),
    .field_if ( field_if )
  );

  assign entry_o = field_if.entry;

endmodule

`default_nettype wire

/* dbg_uart_server_chk.sv */
////////////////////////////////////////////////////////////
// Concurrent assertions on the debug server top level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module dbg_uart_server_chk import dbg_pkg::*; (
  input logic   clk,
  input logic   rst_i,
  input logic   exec_o,
  input logic   uart_tx_o,
  input entry_t entry_o
);

  // Exec is a single-cycle pulse
  exec_single_cycle: assert property (@(posedge clk) disable iff (rst_i) exec_o |=> !exec_o)
    else $error("exec_o high for two cycles in a row");

  // Idle line level once reset has been sampled
  tx_idle_in_reset: assert property (@(posedge clk) rst_i |=> uart_tx_o)
    else $error("uart_tx_o not high during reset");

  entry_holds: assert property (@(posedge clk) disable iff (rst_i)
    !$stable(entry_o) |-> $rose(exec_o))
    else $error("entry_o changed without an exec pulse");

endmodule

bind dbg_uart_server dbg_uart_server_chk i_dbg_uart_server_chk (
  .clk       ( clk       ),
  .rst_i     ( rst_i     ),
  .exec_o    ( exec_o    ),
  .uart_tx_o ( uart_tx_o ),
  .entry_o   ( entry_o   )
);

`default_nettype wire

/* tb_dbg_uart_server.sv */
////////////////////////////////////////////////////////////
// Testbench for the UART debug server: UART host model,
// directed protocol tests and typed compare tasks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_dbg_uart_server import dbg_pkg::*; ();

  localparam int unsigned ClksPerBit = 16;
  localparam int unsigned HdrBytes   = 16;
  // Bytes on the wire per test, in both directions
  localparam int unsigned TestBytes  = 2 + 2 * (1 + HdrBytes + 1 + 16 + 1) +
                                       2 * (1 + HdrBytes + 1 + 8 + 1) +
                                       (1 + 8 + 1) + (1 + 4) + 3;
  localparam int unsigned CycleLimit = TestBytes * 10 * ClksPerBit * 2;
  localparam int unsigned ReplyWait  = 40 * ClksPerBit;
  localparam int unsigned QuietWait  = 30 * ClksPerBit;

  logic   clk;
  logic   rst_i;
  logic   uart_rx_i;
  logic   eoc_i;
  word_t  exit_code_i;
  logic   uart_tx_o;
  logic   exec_o;
  entry_t entry_o;

  int unsigned cycle_count = 0;
  int unsigned exec_count  = 0;
  int unsigned err_count   = 0;
  int unsigned err_base    = 0;
  int unsigned test_count  = 0;
  int unsigned fail_count  = 0;
  string       test_name;
  logic [31:0] lcg_state;
  byte_t       ref_data [16];

  dbg_uart_server #(
    .ClksPerBit ( ClksPerBit )
  ) i_dbg_uart_server (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .uart_rx_i   ( uart_rx_i   ),
    .eoc_i       ( eoc_i       ),
    .exit_code_i ( exit_code_i ),
    .uart_tx_o   ( uart_tx_o   ),
    .exec_o      ( exec_o      ),
    .entry_o     ( entry_o     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog and exec pulse counter
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (exec_o) begin
      exec_count <= exec_count + 1;
    end
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: run exceeded %0d cycles without finishing", CycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random data and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic byte_t next_rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_entry(input string name, input entry_t got, input entry_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got 0x%016h, expected 0x%016h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_pulse_count(input string name, input int unsigned got,
                                   input int unsigned exp);
    if (got != exp) begin
      $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // UART host model
  ////////////////////////////////////////////////////////////

  // Start bit, 8 data bits LSB first, stop bit
  task automatic uart_send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx_i = frame[i];
      repeat (ClksPerBit - 1) @(negedge clk);
    end
  endtask

  // Returns in the middle of the stop bit
  task automatic uart_recv_byte(output byte_t data);
    int unsigned waited;
    data   = 8'h00;
    waited = 0;
    @(negedge clk);
    while (uart_tx_o !== 1'b0 && waited < ReplyWait) begin
      @(negedge clk);
      waited++;
    end
    if (uart_tx_o !== 1'b0) begin
      $display("Error at %0t ns: no reply byte started on uart_tx_o", $time);
      err_count++;
    end else begin
      repeat (ClksPerBit / 2) @(negedge clk);
      if (uart_tx_o !== 1'b0) begin
        $display("Error at %0t ns: start bit on uart_tx_o ended early", $time);
        err_count++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (ClksPerBit) @(negedge clk);
        data[i] = uart_tx_o;
      end
      repeat (ClksPerBit) @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        $display("Error at %0t ns: stop bit missing on uart_tx_o", $time);
        err_count++;
      end
    end
  endtask

  task automatic expect_quiet_line(input int unsigned cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      $display("Error at %0t ns: DUT replied although no reply was due", $time);
      err_count++;
    end
  endtask

  // Command byte, 8 address bytes and optionally 8 length bytes, little-endian
  task automatic send_command(input byte_t cmd, input entry_t addr, input entry_t count,
                              input logic with_len);
    uart_send_byte(cmd);
    for (int i = 0; i < 8; i++) begin
      uart_send_byte(addr[8*i +: 8]);
    end
    if (with_len) begin
      for (int i = 0; i < 8; i++) begin
        uart_send_byte(count[8*i +: 8]);
      end
    end
  endtask

  task automatic write_block(input entry_t addr, input int unsigned count);
    byte_t got;
    send_command(CmdWrite, addr, entry_t'(count), 1'b1);
    uart_recv_byte(got);
    check_byte("write ack", got, RespAck);
    for (int i = 0; i < count; i++) begin
      uart_send_byte(ref_data[i]);
    end
    uart_recv_byte(got);
    check_byte("write eot", got, RespEot);
  endtask

  task automatic read_block(input entry_t addr, input int unsigned count);
    byte_t got;
    send_command(CmdRead, addr, entry_t'(count), 1'b1);
    uart_recv_byte(got);
    check_byte("read ack", got, RespAck);
    for (int i = 0; i < count; i++) begin
      uart_recv_byte(got);
      check_byte("read data", got, ref_data[i]);
    end
    uart_recv_byte(got);
    check_byte("read eot", got, RespEot);
  endtask

  task automatic open_test(input string name);
    test_name = name;
    err_base  = err_count;
  endtask

  task automatic close_test();
    test_count++;
    if (err_count == err_base) begin
      $display("Test %s: passed", test_name);
    end else begin
      fail_count++;
      $display("Test %s: failed with %0d errors", test_name, err_count - err_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_ack_challenge();
    byte_t got;
    open_test("ack challenge");
    uart_send_byte(RespAck);
    uart_recv_byte(got);
    check_byte("ack reply", got, RespAck);
    close_test();
  endtask

  task automatic test_write_read();
    open_test("write then read");
    for (int i = 0; i < 16; i++) begin
      ref_data[i] = next_rand_byte();
    end
    write_block(64'h20, 16);
    read_block(64'h20, 16);
    close_test();
  endtask

  // Four bytes at the top of memory, four after the wrap to index 0
  task automatic test_address_wrap();
    open_test("address wrap");
    for (int i = 0; i < 8; i++) begin
      ref_data[i] = next_rand_byte();
    end
    write_block(64'hFC, 8);
    read_block(64'hFC, 8);
    close_test();
  endtask

  task automatic test_exec();
    entry_t      entry;
    byte_t       got;
    int unsigned base;
    open_test("exec");
    for (int i = 0; i < 8; i++) begin
      entry[8*i +: 8] = next_rand_byte();
    end
    base = exec_count;
    send_command(CmdExec, entry, 64'h0, 1'b0);
    uart_recv_byte(got);
    check_byte("exec ack", got, RespAck);
    check_pulse_count("exec_o pulses", exec_count - base, 1);
    check_entry("entry_o", entry_o, entry);
    close_test();
  endtask

  task automatic test_end_of_computation();
    word_t code;
    byte_t got;
    open_test("end of computation");
    for (int i = 0; i < 4; i++) begin
      code[8*i +: 8] = next_rand_byte();
    end
    @(negedge clk);
    eoc_i       = 1'b1;
    exit_code_i = code;
    // Code must be latched in the eoc cycle
    @(negedge clk);
    eoc_i       = 1'b0;
    exit_code_i = '0;
    uart_recv_byte(got);
    check_byte("eoc reply", got, RespEoc);
    for (int i = 0; i < 4; i++) begin
      uart_recv_byte(got);
      check_byte("exit code byte", got, code[8*i +: 8]);
    end
    close_test();
  endtask

  task automatic test_unknown_command();
    byte_t got;
    open_test("unknown command");
    uart_send_byte(8'h55);
    expect_quiet_line(QuietWait);
    uart_send_byte(RespAck);
    uart_recv_byte(got);
    check_byte("ack after unknown", got, RespAck);
    close_test();
  endtask

  initial begin
    rst_i       = 1'b1;
    uart_rx_i   = 1'b1;
    eoc_i       = 1'b0;
    exit_code_i = '0;
    lcg_state   = 32'd21;
    repeat (2) @(negedge clk);
    rst_i = 1'b0;
    repeat (4) @(negedge clk);

    test_ack_challenge();
    test_write_read();
    test_address_wrap();
    test_exec();
    test_end_of_computation();
    test_unknown_command();

    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
dbg_pkg.sv
dbg_field_if.sv
dbg_mem_if.sv
uart_rx.sv
uart_tx.sv
dbg_cmd_fields.sv
dbg_mem.sv
dbg_ctrl.sv
dbg_uart_server.sv
dbg_uart_server_chk.sv
tb_dbg_uart_server.sv

/* run.sh */
#!/bin/sh
# Build and run the UART debug server testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_dbg_uart_server -f verilog.f -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"

# Fails the script unless the pass line was printed
printf '%s\n' "$out" | grep -qF '** PASS **'
